//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= >>> PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- source/alu_arith.sv
// Adder and subtractor for ADD and CMP with carry taps and arithmetic flags
module alu_arith (
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	input  alu_pkg::size_t   datasize,
	input  logic             subtract,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t flags
);

	// Inverted b plus carry-in gives a minus b
	alu_pkg::word_t   b_eff;
	logic [32:0]      full_sum;
	// Carry into each bit position, bit 0 is the carry-in
	alu_pkg::word_t   carry_in;
	// Carry out of the top bit at the chosen size
	logic             size_carry;
	logic             cf;
	logic             af;
	alu_pkg::eflags_t base_flags;

	assign b_eff    = subtract ? ~b : b;
	assign full_sum = {1'b0, a} + {1'b0, b_eff} + {32'b0, subtract};
	assign carry_in = a ^ b_eff ^ full_sum[31:0];
	assign result   = full_sum[31:0];

	// --------------------------------------------------
	// Carry taps
	// --------------------------------------------------
	always_comb begin
		case (datasize)
			alu_pkg::size_byte: size_carry = carry_in[8];
			alu_pkg::size_word: size_carry = carry_in[16];
			default:            size_carry = full_sum[32];
		endcase
	end

	// Borrow is the inverted carry when subtracting
	assign cf = size_carry ^ subtract;
	// Nibble carry, or borrow from bit 3
	assign af = carry_in[4] ^ subtract;

	alu_flag_logic u_flags (
		.result    (result),
		.a         (a),
		.b         (b),
		.datasize  (datasize),
		.carry_out (cf),
		.subtract  (subtract),
		.flags     (base_flags)
	);

	// Only AF is added on top of the common flags
	always_comb begin
		flags = base_flags;
		flags[alu_pkg::flag_af] = af;
	end

endmodule

//--- source/alu_core.sv
// Combinational ALU that runs all units in parallel and selects by opcode
module alu_core (
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::size_t   datasize,
	input  logic             cf_in,
	input  logic             af_in,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t flags
);

	alu_pkg::word_t   add_result;
	alu_pkg::word_t   cmp_result;
	alu_pkg::word_t   logic_result;
	alu_pkg::word_t   daa_result;
	alu_pkg::eflags_t add_flags;
	alu_pkg::eflags_t cmp_flags;
	alu_pkg::eflags_t logic_flags;
	alu_pkg::eflags_t daa_flags;

	// --------------------------------------------------
	// Units
	// --------------------------------------------------
	alu_arith u_add (
		.a        (a),
		.b        (b),
		.datasize (datasize),
		.subtract (1'b0),
		.result   (add_result),
		.flags    (add_flags)
	);

	// a minus b, difference goes out as result
	alu_arith u_cmp (
		.a        (a),
		.b        (b),
		.datasize (datasize),
		.subtract (1'b1),
		.result   (cmp_result),
		.flags    (cmp_flags)
	);

	alu_logic_unit u_logic (
		.a        (a),
		.b        (b),
		.datasize (datasize),
		.op       (op),
		.result   (logic_result),
		.flags    (logic_flags)
	);

	alu_daa u_daa (
		.a      (a),
		.cf_in  (cf_in),
		.af_in  (af_in),
		.result (daa_result),
		.flags  (daa_flags)
	);

	// Output select
	always_comb begin
		// CLD and STD: zero result, DF handled in the flag register
		result = '0;
		flags  = alu_pkg::eflags_reset;
		case (op)
			alu_pkg::alu_add: begin
				result = add_result;
				flags  = add_flags;
			end
			alu_pkg::alu_cmp: begin
				result = cmp_result;
				flags  = cmp_flags;
			end
			alu_pkg::alu_and, alu_pkg::alu_or, alu_pkg::alu_not: begin
				result = logic_result;
				flags  = logic_flags;
			end
			alu_pkg::alu_daa: begin
				result = daa_result;
				flags  = daa_flags;
			end
			default: begin
				result = '0;
				flags  = alu_pkg::eflags_reset;
			end
		endcase
	end

endmodule

//--- source/alu_daa.sv
// Decimal adjust of the low byte after a packed BCD add, with its own flags
module alu_daa (
	input  alu_pkg::word_t   a,
	input  logic             cf_in,
	input  logic             af_in,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t flags
);

	logic [7:0] al;
	logic [7:0] al_step1;
	logic [7:0] al_step2;
	// Adjust requests for each digit
	logic       low_adj;
	logic       high_adj;

	assign al = a[7:0];

	// --------------------------------------------------
	// Low digit
	// --------------------------------------------------
	// Nibble past 9 or a carry out of it last time
	assign low_adj  = (al[3:0] > 4'd9) || af_in;
	assign al_step1 = low_adj ? al + 8'h06 : al;

	// --------------------------------------------------
	// High digit
	// --------------------------------------------------
	// Decided on the original byte, not on step 1
	assign high_adj = (al > 8'h99) || cf_in;
	assign al_step2 = high_adj ? al_step1 + 8'h60 : al_step1;

	// Upper bytes are cleared
	assign result = {24'b0, al_step2};

	always_comb begin
		flags = alu_pkg::eflags_reset;
		flags[alu_pkg::flag_af] = low_adj;
		flags[alu_pkg::flag_cf] = high_adj;
		flags[alu_pkg::flag_zf] = (al_step2 == 8'h00);
		flags[alu_pkg::flag_pf] = ~^al_step2;
		// BCD is unsigned so SF stays low
		flags[alu_pkg::flag_sf] = 1'b0;
		flags[alu_pkg::flag_of] = 1'b0;
	end

endmodule

//--- source/alu_flag_logic.sv
// Size-aware SF, ZF, PF, CF and OF generation for one ALU result
module alu_flag_logic (
	input  alu_pkg::word_t   result,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	input  alu_pkg::size_t   datasize,
	input  logic             carry_out,
	input  logic             subtract,
	output alu_pkg::eflags_t flags
);

	// Second operand as the adder really sees it
	alu_pkg::word_t b_eff;
	// Mask for the zero test
	alu_pkg::word_t size_mask;
	// Sign bits at the selected size
	logic r_sign;
	logic a_sign;
	logic b_sign;

	assign b_eff = subtract ? ~b : b;

	// Pick top bit and mask by operand size
	always_comb begin
		case (datasize)
			alu_pkg::size_byte: begin
				size_mask = 32'h0000_00ff;
				r_sign    = result[7];
				a_sign    = a[7];
				b_sign    = b_eff[7];
			end
			alu_pkg::size_word: begin
				size_mask = 32'h0000_ffff;
				r_sign    = result[15];
				a_sign    = a[15];
				b_sign    = b_eff[15];
			end
			alu_pkg::size_dword: begin
				size_mask = 32'hffff_ffff;
				r_sign    = result[31];
				a_sign    = a[31];
				b_sign    = b_eff[31];
			end
			default: begin
				// Code 3 acts as dword
				size_mask = 32'hffff_ffff;
				r_sign    = result[31];
				a_sign    = a[31];
				b_sign    = b_eff[31];
			end
		endcase
	end

	always_comb begin
		flags = alu_pkg::eflags_reset;
		flags[alu_pkg::flag_sf] = r_sign;
		flags[alu_pkg::flag_zf] = ((result & size_mask) == '0);
		// Even parity of low byte only
		flags[alu_pkg::flag_pf] = ~^result[7:0];
		// Carry already resolved at the size boundary by the caller
		flags[alu_pkg::flag_cf] = carry_out;
		// Same-signed inputs giving a differently signed result
		flags[alu_pkg::flag_of] = (a_sign == b_sign) && (r_sign != a_sign);
	end

endmodule

//--- source/alu_logic_unit.sv
// Bitwise AND, OR and NOT with logical-operation flags
module alu_logic_unit (
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	input  alu_pkg::size_t   datasize,
	input  alu_pkg::alu_op_t op,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t flags
);

	alu_pkg::eflags_t base_flags;

	always_comb begin
		case (op)
			alu_pkg::alu_and: result = a & b;
			alu_pkg::alu_or:  result = a | b;
			alu_pkg::alu_not: result = ~a;
			// Other opcodes never reach this result
			default:          result = ~a;
		endcase
	end

	// No carry chain here
	alu_flag_logic u_flags (
		.result    (result),
		.a         (a),
		.b         (b),
		.datasize  (datasize),
		.carry_out (1'b0),
		.subtract  (1'b0),
		.flags     (base_flags)
	);

	// Logical ops keep SF, ZF, PF and clear the rest
	always_comb begin
		flags = base_flags;
		flags[alu_pkg::flag_of] = 1'b0;
		flags[alu_pkg::flag_cf] = 1'b0;
		flags[alu_pkg::flag_af] = 1'b0;
	end

endmodule

//--- source/alu_pkg.sv
// Execute stage package with data widths, operand sizes, opcodes and EFLAGS layout
package alu_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int word_w  = 32;
	localparam int flags_w = 32;

	// Operand and result word
	typedef logic [word_w-1:0] word_t;

	// Architectural EFLAGS, only seven bits ever set
	typedef logic [flags_w-1:0] eflags_t;

	// Operand size code
	typedef logic [1:0] size_t;

	// --------------------------------------------------
	// Operand size codes
	// --------------------------------------------------
	// Code 3 is treated as dword
	localparam size_t size_byte  = 2'd0;
	localparam size_t size_word  = 2'd1;
	localparam size_t size_dword = 2'd2;

	// Opcodes as seen by the stage
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_or  = 3'd1,
		alu_not = 3'd2,
		alu_daa = 3'd3,
		alu_and = 3'd4,
		alu_cld = 3'd5,
		alu_cmp = 3'd6,
		alu_std = 3'd7
	} alu_op_t;

	// --------------------------------------------------
	// EFLAGS bit positions
	// --------------------------------------------------
	localparam int flag_cf = 0;
	localparam int flag_pf = 2;
	localparam int flag_af = 4;
	localparam int flag_zf = 6;
	localparam int flag_sf = 7;
	localparam int flag_df = 10;
	localparam int flag_of = 11;

	// Value after reset, also the base for every unit's flag word
	localparam eflags_t eflags_reset = '0;

endpackage

//--- source/eflags_reg.sv
// Architectural EFLAGS register with per-opcode write rules and DF control
module eflags_reg (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::eflags_t alu_flags,
	output alu_pkg::eflags_t eflags,
	output logic             cf_fwd,
	output logic             af_fwd
);

	alu_pkg::eflags_t eflags_next;

	// --------------------------------------------------
	// Write rules
	// --------------------------------------------------
	always_comb begin
		eflags_next = eflags;
		case (op)
			alu_pkg::alu_add, alu_pkg::alu_or, alu_pkg::alu_and,
			alu_pkg::alu_cmp, alu_pkg::alu_daa: begin
				// All status flags replaced, DF kept
				eflags_next = alu_flags;
				eflags_next[alu_pkg::flag_df] = eflags[alu_pkg::flag_df];
			end
			alu_pkg::alu_cld: eflags_next[alu_pkg::flag_df] = 1'b0;
			alu_pkg::alu_std: eflags_next[alu_pkg::flag_df] = 1'b1;
			// NOT leaves EFLAGS alone
			default:          eflags_next = eflags;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			eflags <= alu_pkg::eflags_reset;
		end else if (in_valid) begin
			eflags <= eflags_next;
		end
	end

	// Stored carries feed the next op's DAA
	assign cf_fwd = eflags[alu_pkg::flag_cf];
	assign af_fwd = eflags[alu_pkg::flag_af];

endmodule

//--- source/exec_stage.sv
// Integer execute stage top with one register stage around the ALU and EFLAGS
module exec_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::size_t   datasize,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	output logic             out_valid,
	output alu_pkg::word_t   result,
	output alu_pkg::eflags_t eflags
);

	alu_pkg::word_t   alu_result;
	alu_pkg::eflags_t alu_flags;
	// Flags from the last accepted op
	logic             cf_in;
	logic             af_in;

	alu_core u_alu (
		.a        (a),
		.b        (b),
		.op       (op),
		.datasize (datasize),
		.cf_in    (cf_in),
		.af_in    (af_in),
		.result   (alu_result),
		.flags    (alu_flags)
	);

	eflags_reg u_eflags (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.alu_flags (alu_flags),
		.eflags    (eflags),
		.cf_fwd    (cf_in),
		.af_fwd    (af_in)
	);

	// Result and strobe register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			result    <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				result <= alu_result;
			end
		end
	end

endmodule

//--- tb.f
source/alu_pkg.sv
source/alu_flag_logic.sv
source/alu_arith.sv
source/alu_logic_unit.sv
source/alu_daa.sv
source/alu_core.sv
source/eflags_reg.sv
source/exec_stage.sv
verif/exec_stage_checker.sv
verif/exec_stage_monitor.sv
verif/exec_stage_tb.sv

//--- verif/exec_stage_checker.sv
// Bound assertions on reset, strobe timing and DF updates of the execute stage
module exec_stage_checker (
	input logic             clk,
	input logic             rst_n,
	input logic             in_valid,
	input logic             out_valid,
	input alu_pkg::alu_op_t op,
	input alu_pkg::eflags_t eflags
);

	// Failed assertions, read by the testbench top
	int failures = 0;

	// --------------------------------------------------
	// Reset
	// --------------------------------------------------
	// Nothing comes out while reset is held
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			$error("out_valid high while reset is held");
			failures++;
		end

	// First edge out of reset still quiet
	a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
		else begin
			$error("out_valid high on the first edge after reset");
			failures++;
		end

	// --------------------------------------------------
	// Strobe timing
	// --------------------------------------------------
	a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |=> out_valid)
		else begin
			$error("out_valid missing one cycle after in_valid");
			failures++;
		end

	a_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!in_valid |=> !out_valid)
		else begin
			$error("out_valid high without in_valid one cycle before");
			failures++;
		end

	// DF moves only under an accepted CLD or STD
	a_df_source: assert property (@(posedge clk) disable iff (!rst_n)
		(eflags[alu_pkg::flag_df] != $past(eflags[alu_pkg::flag_df])) |->
		($past(in_valid) && ($past(op) == alu_pkg::alu_cld || $past(op) == alu_pkg::alu_std)))
		else begin
			$error("DF changed without a CLD or STD");
			failures++;
		end

endmodule

//--- verif/exec_stage_monitor.sv
// Watches the execute stage outputs and compares them with the expected response
module exec_stage_monitor (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic             out_valid,
	input  alu_pkg::word_t   result,
	input  alu_pkg::eflags_t eflags,
	input  alu_pkg::word_t   exp_result,
	input  alu_pkg::eflags_t exp_eflags,
	output int               mismatches,
	output int               checked
);

	// Strobe seen on the last edge, with its expected response
	logic             pending;
	alu_pkg::word_t   pend_result;
	alu_pkg::eflags_t pend_eflags;
	// Last response, outputs keep it while idle
	alu_pkg::word_t   hold_result;
	alu_pkg::eflags_t hold_eflags;
	int               err_count = 0;
	int               check_count = 0;

	assign mismatches = err_count;
	assign checked    = check_count;

	// Capture expectations where the DUT samples its inputs
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else begin
			pending <= in_valid;
			if (in_valid) begin
				pend_result <= exp_result;
				pend_eflags <= exp_eflags;
			end
		end
	end

	// --------------------------------------------------
	// Compare mid-cycle, outputs settled
	// --------------------------------------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			hold_result = '0;
			hold_eflags = alu_pkg::eflags_reset;
			if (out_valid !== 1'b0 || result !== '0 || eflags !== alu_pkg::eflags_reset) begin
				$display("mismatch at %0t: reset state out_valid %b result %h eflags %h",
					$time, out_valid, result, eflags);
				err_count++;
			end
		end else if (pending) begin
			check_count++;
			if (out_valid !== 1'b1) begin
				$display("mismatch at %0t: out_valid low one cycle after a strobe", $time);
				err_count++;
			end
			if (result !== pend_result) begin
				$display("mismatch at %0t: result %h, expected %h", $time, result, pend_result);
				err_count++;
			end
			if (eflags !== pend_eflags) begin
				$display("mismatch at %0t: eflags %h, expected %h", $time, eflags, pend_eflags);
				err_count++;
			end
			hold_result = pend_result;
			hold_eflags = pend_eflags;
		end else begin
			if (out_valid !== 1'b0) begin
				// Latency other than one cycle lands here
				$display("mismatch at %0t: out_valid high without a strobe one cycle before",
					$time);
				err_count++;
			end
			// Idle cycles leave result and EFLAGS alone
			if (result !== hold_result || eflags !== hold_eflags) begin
				$display("mismatch at %0t: idle result %h eflags %h, expected %h %h",
					$time, result, eflags, hold_result, hold_eflags);
				err_count++;
			end
		end
	end

endmodule

//--- verif/exec_stage_tb.sv
// Testbench top for the execute stage, applies the vector file and reports the outcome
module exec_stage_tb;

	localparam int    clk_period   = 4;
	localparam int    reset_cycles = 4;
	// Cycles allowed for out_valid after a strobe
	localparam int    valid_wait   = 8;
	// Hard cap on the whole run
	localparam int    run_cycles   = 1000;
	localparam string vector_path  = "verif/exec_vectors.txt";

	// Starts low with no edge at time zero
	logic             clk = 1'b0;
	logic             rst_n;
	logic             in_valid;
	alu_pkg::alu_op_t op;
	alu_pkg::size_t   datasize;
	alu_pkg::word_t   a;
	alu_pkg::word_t   b;
	logic             out_valid;
	alu_pkg::word_t   result;
	alu_pkg::eflags_t eflags;
	// Expected response of the op being strobed
	alu_pkg::word_t   exp_result;
	alu_pkg::eflags_t exp_eflags;
	int               mismatches;
	int               checked;
	int               other_errors;
	int               applied;

	exec_stage dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.datasize  (datasize),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.eflags    (eflags)
	);

	exec_stage_monitor monitor_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.out_valid  (out_valid),
		.result     (result),
		.eflags     (eflags),
		.exp_result (exp_result),
		.exp_eflags (exp_eflags),
		.mismatches (mismatches),
		.checked    (checked)
	);

	bind exec_stage exec_stage_checker checker_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.op        (op),
		.eflags    (eflags)
	);

	initial begin
		forever #(clk_period / 2) clk = ~clk;
	end

	// Closing line with all counts, then the verdict
	task automatic report_and_finish;
		int assert_errors;
		assert_errors = dut_i.checker_i.failures;
		$display("errors: mismatch %0d, assertion %0d, other %0d (%0d of %0d ops checked)",
			mismatches, assert_errors, other_errors, checked, applied);
		if (mismatches == 0 && assert_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	// One strobe, called at 1 unit past an edge
	task automatic apply_op(input alu_pkg::alu_op_t v_op, input alu_pkg::size_t v_size,
		input alu_pkg::word_t v_a, input alu_pkg::word_t v_b,
		input alu_pkg::word_t v_result, input alu_pkg::eflags_t v_eflags,
		output bit timed_out);
		int waited;
		waited     = 0;
		timed_out  = 1'b0;
		in_valid   = 1'b1;
		op         = v_op;
		datasize   = v_size;
		a          = v_a;
		b          = v_b;
		exp_result = v_result;
		exp_eflags = v_eflags;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		// Already high when latency is one, no extra cycle spent
		while (out_valid !== 1'b1 && waited < valid_wait) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (out_valid !== 1'b1) begin
			$display("out_valid did not rise within %0d cycles of an operation", valid_wait);
			other_errors++;
			timed_out = 1'b1;
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int          fd;
		int          gap;
		int          idle;
		int          fields;
		string       line;
		logic [31:0] f_op;
		logic [31:0] f_size;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_res;
		logic [31:0] f_flags;
		bit          timed_out;
		bit          stop;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		op           = alu_pkg::alu_add;
		datasize     = alu_pkg::size_byte;
		a            = '0;
		b            = '0;
		exp_result   = '0;
		exp_eflags   = alu_pkg::eflags_reset;
		other_errors = 0;
		applied      = 0;
		timed_out    = 1'b0;
		stop         = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		fd = $fopen(vector_path, "r");
		if (fd == 0) begin
			$display("could not open the vector file %s", vector_path);
			other_errors++;
		end else begin
			while (!stop && !$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Comment and blank lines scan no fields
				fields = $sscanf(line, "%d %h %h %h %h %h %h",
					gap, f_op, f_size, f_a, f_b, f_res, f_flags);
				if (fields == 7) begin
					for (idle = 0; idle < gap; idle++) begin
						@(posedge clk);
						#1;
					end
					apply_op(alu_pkg::alu_op_t'(f_op[2:0]), f_size[1:0], f_a, f_b,
						f_res, f_flags, timed_out);
					applied++;
					stop = timed_out;
				end else if (fields > 0) begin
					$display("malformed line in the vector file: %s", line);
					other_errors++;
				end
			end
			$fclose(fd);
		end
		if (applied == 0) begin
			$display("no operations were read from the vector file");
			other_errors++;
		end
		// Let the last compare happen
		repeat (2) @(posedge clk);
		if (checked != applied) begin
			$display("only %0d of %0d operations reached a compare", checked, applied);
			other_errors++;
		end
		report_and_finish();
	end

	// Watchdog over the whole run
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < run_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", run_cycles);
		other_errors++;
		report_and_finish();
	end

endmodule

//--- verif/exec_vectors.txt
# gap(dec) op size a b result eflags, all but gap in hex
# op: 0 add 1 or 2 not 3 daa 4 and 5 cld 6 cmp 7 std, size: 0 byte 1 word 2 dword
2 0 0 000000ff 00000001 00000100 00000055
0 0 0 0000007f 00000001 00000080 00000890
0 0 0 000001f0 00000020 00000210 00000001
0 0 1 0000ffff 00000001 00010000 00000055
0 0 1 00007000 00001000 00008000 00000884
0 0 2 ffffffff 00000001 00000000 00000055
0 0 2 7fffffff 00000001 80000000 00000894
0 0 2 12345678 11111111 23456789 00000000
1 0 3 ffffffff 00000001 00000000 00000055
0 6 0 00000055 00000055 00000000 00000044
0 6 0 00000080 00000001 0000007f 00000810
0 6 0 00000001 00000002 ffffffff 00000095
0 6 1 00001234 00001234 00000000 00000044
0 6 1 00009000 00001000 00008000 00000084
0 6 1 00000005 00000100 ffffff05 00000085
0 6 2 80000000 00000001 7fffffff 00000814
0 6 2 00000010 00000020 fffffff0 00000085
0 6 2 deadbeef deadbeef 00000000 00000044
0 4 2 f0f0f0f0 0ff00ff0 00f000f0 00000004
0 4 0 0000ff0f 0000f0f0 0000f000 00000044
0 1 1 00008001 00000002 00008003 00000084
0 1 2 00000000 00000000 00000000 00000044
0 2 2 0f0f0f0f 00000000 f0f0f0f0 00000044
0 0 0 0000007f 00000001 00000080 00000890
0 2 0 12345678 00000000 edcba987 00000890
0 0 0 00000038 00000045 0000007d 00000004
0 3 0 0000007d 00000000 00000083 00000010
0 0 0 00000058 00000049 000000a1 00000890
3 3 0 000000a1 00000000 00000007 00000011
0 0 0 00000099 00000099 00000132 00000811
0 3 0 00000132 00000000 00000098 00000011
1 7 2 00000000 00000000 00000000 00000411
0 0 2 00000001 00000001 00000002 00000400
0 6 0 00000010 00000010 00000000 00000444
0 3 0 00000000 00000000 00000000 00000444
0 5 2 00000000 00000000 00000000 00000044
0 4 2 ffffffff 80000000 80000000 00000084
0 1 2 00000001 00000000 00000001 00000000
